// ==== ddr_model_pkg.sv ====
// DDR4 model shared definitions
`default_nettype none

package ddr_model_pkg;

   //////////////////////////////////////////////////
   // Pin and index widths
   //////////////////////////////////////////////////

   localparam int addr_w = 17;
   localparam int ba_w   = 2;
   localparam int bg_w   = 1;

   // Bank group sits above the bank address in the combined index
   localparam int bank_w = bg_w + ba_w;

   //////////////////////////////////////////////////
   // Command decode
   //////////////////////////////////////////////////

   typedef enum logic [2:0] {
      cmd_nop,
      cmd_act,
      cmd_pre,
      cmd_wr,
      cmd_rd
   } ddr_cmd_e;

   // RAS_n, CAS_n and WE_n as carried on A16, A15 and A14 while act_n is high
   localparam logic [2:0] ca_pre = 3'b010;
   localparam logic [2:0] ca_wr  = 3'b100;
   localparam logic [2:0] ca_rd  = 3'b101;
   localparam logic [2:0] ca_nop = 3'b111;

   // Command view of the address pins
   typedef struct packed {
      logic              ras_n;
      logic              cas_n;
      logic              we_n;
      logic [addr_w-4:0] col;
   } ddr_ca_cmd_t;

   // The same mem_a word is a full row address during ACT and a
   // command word with a column field otherwise
   typedef union packed {
      logic [addr_w-1:0] row;
      ddr_ca_cmd_t       cmd;
   } ddr_ca_word_u;

endpackage

`default_nettype wire

// ==== ddr_cmd_if.sv ====
// Decoded command bus
`timescale 1ns/1ps
`default_nettype none

interface ddr_cmd_if
   import ddr_model_pkg::*;
#(
   parameter int n_ranks = 2,
   parameter int row_w   = 4,
   parameter int col_w   = 3,
   parameter int dq_w    = 16
);
   localparam int rank_w = (n_ranks > 1) ? $clog2(n_ranks) : 1;

   // One strobe per accepted command, at most one high per cycle
   logic              act;
   logic              pre;
   logic              wr;
   logic              rd;

   logic [rank_w-1:0] rank;
   logic [bank_w-1:0] bank;
   logic [row_w-1:0]  row;
   logic [col_w-1:0]  col;
   logic [dq_w-1:0]   wdata;

   // State of the addressed rank and bank, looked up by the tracker
   logic              bank_open;
   logic [row_w-1:0]  open_row;

   modport ctrl (
      output act, pre, wr, rd, rank, bank, row, col, wdata,
      input  bank_open, open_row
   );

   modport tracker (
      input  act, pre, rank, bank, row,
      output bank_open, open_row
   );

   modport store (
      input  wr, rd, rank, bank, row, col, wdata
   );

endinterface

`default_nettype wire

// ==== ddr_cmd_ctrl.sv ====
// Command decode and protocol checks
`timescale 1ns/1ps
`default_nettype none

module ddr_cmd_ctrl
   import ddr_model_pkg::*;
#(
   parameter int n_ranks = 2,
   parameter int row_w   = 4,
   parameter int col_w   = 3,
   parameter int dq_w    = 16
) (
   input  logic               mem_ck,
   input  logic               arst_n,
   input  logic               mem_act_n,
   input  logic [n_ranks-1:0] mem_cs_n,
   input  logic [addr_w-1:0]  mem_a,
   input  logic [ba_w-1:0]    mem_ba,
   input  logic [bg_w-1:0]    mem_bg,
   input  logic               mem_par,
   input  logic [dq_w-1:0]    mem_dq_in,
   output logic               mem_alert_n,
   ddr_cmd_if.ctrl            cmd
);
   localparam int rank_w = (n_ranks > 1) ? $clog2(n_ranks) : 1;
   localparam int cnt_w  = $clog2(n_ranks + 1);

   ddr_ca_word_u      ca;
   ddr_cmd_e          kind;
   logic [cnt_w-1:0]  cs_cnt;
   logic [rank_w-1:0] rank_idx;
   logic              selected;
   logic              multi_cs;
   logic              par_ok;
   logic              state_err;
   logic              legal;
   logic              err;
   logic              alert_q;

   //////////////////////////////////////////////////
   // Command and rank decode
   //////////////////////////////////////////////////

   assign ca = mem_a;

   always_comb begin
      if (!mem_act_n) begin
         kind = cmd_act;
      end else begin
         case ({ca.cmd.ras_n, ca.cmd.cas_n, ca.cmd.we_n})
            ca_pre:  kind = cmd_pre;
            ca_wr:   kind = cmd_wr;
            ca_rd:   kind = cmd_rd;
            ca_nop:  kind = cmd_nop;
            // Refresh, mode register and the rest are ignored here
            default: kind = cmd_nop;
         endcase
      end
   end

   // Count the low chip selects and keep the index of the last one
   always_comb begin
      cs_cnt   = '0;
      rank_idx = '0;
      for (int i = 0; i < n_ranks; i++) begin
         if (!mem_cs_n[i]) begin
            cs_cnt   = cs_cnt + 1'b1;
            rank_idx = rank_w'(i);
         end
      end
   end

   assign selected = (cs_cnt != '0);
   assign multi_cs = (cs_cnt > cnt_w'(1));

   //////////////////////////////////////////////////
   // Error checks
   //////////////////////////////////////////////////

   // Even parity over the whole command and address group
   assign par_ok = ~^{mem_par, mem_act_n, mem_a, mem_ba, mem_bg};

   assign state_err = ((kind == cmd_act) && cmd.bank_open) ||
                      (((kind == cmd_wr) || (kind == cmd_rd)) && !cmd.bank_open);

   assign legal = selected && !multi_cs && par_ok && !state_err;
   assign err   = selected && (multi_cs || !par_ok || state_err);

   //////////////////////////////////////////////////
   // Outputs to the datapath
   //////////////////////////////////////////////////

   assign cmd.act = legal && (kind == cmd_act);
   assign cmd.pre = legal && (kind == cmd_pre);
   assign cmd.wr  = legal && (kind == cmd_wr);
   assign cmd.rd  = legal && (kind == cmd_rd);

   assign cmd.rank  = rank_idx;
   assign cmd.bank  = {mem_bg, mem_ba};
   assign cmd.col   = ca.cmd.col[col_w-1:0];
   assign cmd.wdata = mem_dq_in;

   // Column commands carry no row, so they use whatever the bank has open
   assign cmd.row = (kind == cmd_act) ? ca.row[row_w-1:0] : cmd.open_row;

   // Alert pulse for the cycle after a rejected command
   always_ff @(posedge mem_ck or negedge arst_n) begin
      if (!arst_n) begin
         alert_q <= 1'b0;
      end else begin
         alert_q <= err;
      end
   end

   assign mem_alert_n = ~alert_q;

   a_one_strobe: assert property (
      @(posedge mem_ck) disable iff (!arst_n)
      $onehot0({cmd.act, cmd.pre, cmd.wr, cmd.rd})
   ) else $error("More than one command strobe in a cycle");

endmodule

`default_nettype wire

// ==== ddr_row_tracker.sv ====
// Open row state per rank and bank
`timescale 1ns/1ps
`default_nettype none

module ddr_row_tracker
   import ddr_model_pkg::*;
#(
   parameter int n_ranks = 2,
   parameter int row_w   = 4
) (
   input  logic       mem_ck,
   input  logic       arst_n,
   ddr_cmd_if.tracker cmd
);
   localparam int bank_n = 2 ** bank_w;

   logic [n_ranks-1:0][bank_n-1:0] open_q;
   logic [row_w-1:0]               row_q [n_ranks][bank_n];

   //////////////////////////////////////////////////
   // Bank state update
   //////////////////////////////////////////////////

   always_ff @(posedge mem_ck or negedge arst_n) begin
      if (!arst_n) begin
         open_q <= '0;
      end else if (cmd.act) begin
         open_q[cmd.rank][cmd.bank] <= 1'b1;
      end else if (cmd.pre) begin
         // Precharge of an idle bank simply leaves it closed
         open_q[cmd.rank][cmd.bank] <= 1'b0;
      end
   end

   // The row is only meaningful while the open flag is set
   always_ff @(posedge mem_ck) begin
      if (cmd.act) begin
         row_q[cmd.rank][cmd.bank] <= cmd.row;
      end
   end

   //////////////////////////////////////////////////
   // Lookup of the addressed bank
   //////////////////////////////////////////////////

   assign cmd.bank_open = open_q[cmd.rank][cmd.bank];
   assign cmd.open_row  = row_q[cmd.rank][cmd.bank];

   // The control module must filter activates to banks that are already open
   a_act_closed: assert property (
      @(posedge mem_ck) disable iff (!arst_n)
      cmd.act |-> !cmd.bank_open
   ) else $error("Activate reached an open bank");

endmodule

`default_nettype wire

// ==== ddr_storage.sv ====
// Memory array with registered read
`timescale 1ns/1ps
`default_nettype none

module ddr_storage
   import ddr_model_pkg::*;
#(
   parameter int n_ranks = 2,
   parameter int row_w   = 4,
   parameter int col_w   = 3,
   parameter int dq_w    = 16
) (
   input  logic            mem_ck,
   input  logic            arst_n,
   ddr_cmd_if.store        cmd,
   output logic [dq_w-1:0] rdata,
   output logic            rvalid
);
   localparam int rank_w    = (n_ranks > 1) ? $clog2(n_ranks) : 1;
   localparam int store_a_w = rank_w + bank_w + row_w + col_w;
   localparam int depth     = 2 ** store_a_w;

   logic [dq_w-1:0]      mem_q [depth];
   logic [store_a_w-1:0] store_addr;

   // Ranks are folded into the top of one flat array
   assign store_addr = {cmd.rank, cmd.bank, cmd.row, cmd.col};

   //////////////////////////////////////////////////
   // Write and read ports
   //////////////////////////////////////////////////

   always_ff @(posedge mem_ck) begin
      if (cmd.wr) begin
         mem_q[store_addr] <= cmd.wdata;
      end
   end

   always_ff @(posedge mem_ck) begin
      if (cmd.rd) begin
         rdata <= mem_q[store_addr];
      end
   end

   always_ff @(posedge mem_ck or negedge arst_n) begin
      if (!arst_n) begin
         rvalid <= 1'b0;
      end else begin
         rvalid <= cmd.rd;
      end
   end

endmodule

`default_nettype wire

// ==== ddr_read_pipe.sv ====
// CAS latency delay line
`timescale 1ns/1ps
`default_nettype none

module ddr_read_pipe #(
   parameter int dq_w    = 16,
   parameter int cas_lat = 4
) (
   input  logic            mem_ck,
   input  logic            arst_n,
   input  logic [dq_w-1:0] rdata,
   input  logic            rvalid,
   output logic [dq_w-1:0] mem_dq_out,
   output logic            mem_dq_oe
);
   // The storage read register already provides the first cycle
   localparam int n_stg = cas_lat - 1;
   localparam int cnt_w = $clog2(cas_lat + 1);

   logic [n_stg-1:0] valid_q;
   logic [dq_w-1:0]  data_q [n_stg];
   logic [cnt_w-1:0] since_rst;

   //////////////////////////////////////////////////
   // Shift registers
   //////////////////////////////////////////////////

   always_ff @(posedge mem_ck or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
      end else begin
         valid_q[0] <= rvalid;
         for (int i = 1; i < n_stg; i++) begin
            valid_q[i] <= valid_q[i-1];
         end
      end
   end

   // Every stage shifts each cycle so back-to-back reads stay in order
   always_ff @(posedge mem_ck) begin
      data_q[0] <= rdata;
      for (int i = 1; i < n_stg; i++) begin
         data_q[i] <= data_q[i-1];
      end
   end

   assign mem_dq_out = data_q[n_stg-1];
   assign mem_dq_oe  = valid_q[n_stg-1];

   // Cycles since reset release, saturating at the latency
   always_ff @(posedge mem_ck or negedge arst_n) begin
      if (!arst_n) begin
         since_rst <= '0;
      end else if (since_rst != cnt_w'(cas_lat)) begin
         since_rst <= since_rst + 1'b1;
      end
   end

   a_no_early_oe: assert property (
      @(posedge mem_ck) disable iff (!arst_n)
      (since_rst < cnt_w'(cas_lat)) |-> !mem_dq_oe
   ) else $error("Read data driven before a read could have completed");

endmodule

`default_nettype wire

// ==== ddr_model_top.sv ====
// DDR4 behavioural memory model
`timescale 1ns/1ps
`default_nettype none

module ddr_model_top
   import ddr_model_pkg::*;
#(
   parameter int n_ranks = 2,
   parameter int row_w   = 4,
   parameter int col_w   = 3,
   parameter int dq_w    = 16,
   parameter int cas_lat = 4
) (
   input  logic               mem_ck,
   input  logic               arst_n,
   input  logic               mem_act_n,
   input  logic [n_ranks-1:0] mem_cs_n,
   input  logic [addr_w-1:0]  mem_a,
   input  logic [ba_w-1:0]    mem_ba,
   input  logic [bg_w-1:0]    mem_bg,
   input  logic               mem_par,
   input  logic [dq_w-1:0]    mem_dq_in,
   output logic [dq_w-1:0]    mem_dq_out,
   output logic               mem_dq_oe,
   output logic               mem_alert_n
);
   logic [dq_w-1:0] rdata;
   logic            rvalid;

   ddr_cmd_if #(
      .n_ranks (n_ranks),
      .row_w   (row_w),
      .col_w   (col_w),
      .dq_w    (dq_w)
   ) cmd_if ();

   //////////////////////////////////////////////////
   // Command path
   //////////////////////////////////////////////////

   ddr_cmd_ctrl #(
      .n_ranks (n_ranks),
      .row_w   (row_w),
      .col_w   (col_w),
      .dq_w    (dq_w)
   ) ctrl_i (
      .mem_ck      (mem_ck),
      .arst_n      (arst_n),
      .mem_act_n   (mem_act_n),
      .mem_cs_n    (mem_cs_n),
      .mem_a       (mem_a),
      .mem_ba      (mem_ba),
      .mem_bg      (mem_bg),
      .mem_par     (mem_par),
      .mem_dq_in   (mem_dq_in),
      .mem_alert_n (mem_alert_n),
      .cmd         (cmd_if.ctrl)
   );

   ddr_row_tracker #(
      .n_ranks (n_ranks),
      .row_w   (row_w)
   ) tracker_i (
      .mem_ck (mem_ck),
      .arst_n (arst_n),
      .cmd    (cmd_if.tracker)
   );

   //////////////////////////////////////////////////
   // Data path
   //////////////////////////////////////////////////

   ddr_storage #(
      .n_ranks (n_ranks),
      .row_w   (row_w),
      .col_w   (col_w),
      .dq_w    (dq_w)
   ) storage_i (
      .mem_ck (mem_ck),
      .arst_n (arst_n),
      .cmd    (cmd_if.store),
      .rdata  (rdata),
      .rvalid (rvalid)
   );

   ddr_read_pipe #(
      .dq_w    (dq_w),
      .cas_lat (cas_lat)
   ) read_pipe_i (
      .mem_ck     (mem_ck),
      .arst_n     (arst_n),
      .rdata      (rdata),
      .rvalid     (rvalid),
      .mem_dq_out (mem_dq_out),
      .mem_dq_oe  (mem_dq_oe)
   );

endmodule

`default_nettype wire

// ==== tb_ddr_model.sv ====
// DDR4 model testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_model
   import ddr_model_pkg::*;
();
   localparam int n_ranks     = 2;
   localparam int row_w       = 4;
   localparam int col_w       = 3;
   localparam int dq_w        = 16;
   localparam int cas_lat     = 4;
   localparam int clk_period  = 40;
   localparam int n_cmds      = 2000;
   localparam int seed        = 4;
   localparam int watchdog_ns = (n_cmds + cas_lat + 20) * clk_period;
   localparam int rank_w      = (n_ranks > 1) ? $clog2(n_ranks) : 1;
   localparam int n_banks     = 2 ** bank_w;
   localparam int mem_a_w     = rank_w + bank_w + row_w + col_w;

   // Command codes of the reference model
   localparam int op_nop = 0;
   localparam int op_act = 1;
   localparam int op_pre = 2;
   localparam int op_wr  = 3;
   localparam int op_rd  = 4;

   logic               mem_ck = 1'b0;
   logic               arst_n;
   logic               mem_act_n;
   logic [n_ranks-1:0] mem_cs_n;
   logic [addr_w-1:0]  mem_a;
   logic [ba_w-1:0]    mem_ba;
   logic [bg_w-1:0]    mem_bg;
   logic               mem_par;
   logic [dq_w-1:0]    mem_dq_in;
   logic [dq_w-1:0]    mem_dq_out;
   logic               mem_dq_oe;
   logic               mem_alert_n;

   // The next command is built in full before it goes onto the pins
   logic               c_act_n;
   logic [n_ranks-1:0] c_cs_n;
   logic [addr_w-1:0]  c_a;
   logic [ba_w-1:0]    c_ba;
   logic [bg_w-1:0]    c_bg;
   logic               c_par;
   logic [dq_w-1:0]    c_dq;

   logic [n_ranks-1:0][n_banks-1:0] model_open;
   logic [row_w-1:0]                model_row [n_ranks][n_banks];
   logic [dq_w-1:0]                 model_mem [2**mem_a_w];
   logic [2**mem_a_w-1:0]           model_written;

   // Each expected read is due in one given cycle
   int              rd_due [$];
   logic [dq_w-1:0] rd_data [$];
   logic            rd_known [$];

   logic        alert_pending;
   logic        alert_now;
   int          errors;
   int          reads_seen;
   int          compares;
   int          alerts_seen;

   ddr_model_top #(
      .n_ranks (n_ranks),
      .row_w   (row_w),
      .col_w   (col_w),
      .dq_w    (dq_w),
      .cas_lat (cas_lat)
   ) dut_i (
      .mem_ck      (mem_ck),
      .arst_n      (arst_n),
      .mem_act_n   (mem_act_n),
      .mem_cs_n    (mem_cs_n),
      .mem_a       (mem_a),
      .mem_ba      (mem_ba),
      .mem_bg      (mem_bg),
      .mem_par     (mem_par),
      .mem_dq_in   (mem_dq_in),
      .mem_dq_out  (mem_dq_out),
      .mem_dq_oe   (mem_dq_oe),
      .mem_alert_n (mem_alert_n)
   );

   always #(clk_period / 2) mem_ck = ~mem_ck;

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task build_idle();
      c_cs_n  = '1;
      c_act_n = 1'b1;
      c_a     = '1;
      c_ba    = '0;
      c_bg    = '0;
      c_dq    = '0;
      c_par   = ^{c_act_n, c_a, c_ba, c_bg};
   endtask

   task build_random_command();
      logic [31:0]       rnd;
      logic [2:0]        code;
      logic [bank_w-1:0] b;
      logic [rank_w-1:0] r;
      int                mode;
      int                op;
      int                op_sel;
      rnd  = $urandom;
      c_a  = rnd[addr_w-1:0];
      rnd  = $urandom;
      b    = rnd[bank_w-1:0];
      rnd  = $urandom;
      c_dq = rnd[dq_w-1:0];
      rnd  = $urandom % n_ranks;
      r    = rnd[rank_w-1:0];
      mode = $urandom % 100;
      op   = $urandom % 100;
      c_ba = b[ba_w-1:0];
      c_bg = b[bank_w-1:ba_w];
      if (mode < 10) begin
         c_cs_n = '1;
      end else if (mode < 13) begin
         c_cs_n = '0;
      end else begin
         c_cs_n    = '1;
         c_cs_n[r] = 1'b0;
      end
      // Mostly legal traffic for the bank state plus a share of protocol errors
      if (model_open[r][b]) begin
         op_sel = (op < 40) ? op_wr : (op < 75) ? op_rd : (op < 88) ? op_pre :
                  (op < 94) ? op_act : op_nop;
      end else begin
         op_sel = (op < 70) ? op_act : (op < 80) ? op_pre : (op < 88) ? op_rd :
                  (op < 96) ? op_wr : op_nop;
      end
      c_act_n = (op_sel != op_act);
      case (op_sel)
         op_pre: c_a[addr_w-1 -: 3] = 3'b010;
         op_wr:  c_a[addr_w-1 -: 3] = 3'b100;
         op_rd:  c_a[addr_w-1 -: 3] = 3'b101;
         op_nop: begin
            do begin
               rnd  = $urandom;
               code = rnd[2:0];
            end while (code == 3'b010 || code == 3'b100 || code == 3'b101);
            c_a[addr_w-1 -: 3] = code;
         end
         default: ;
      endcase
      c_par = ^{c_act_n, c_a, c_ba, c_bg};
      if ($urandom % 100 < 5) begin
         c_par = ~c_par;
      end
   endtask

   task drive_command();
      mem_act_n <= c_act_n;
      mem_cs_n  <= c_cs_n;
      mem_a     <= c_a;
      mem_ba    <= c_ba;
      mem_bg    <= c_bg;
      mem_par   <= c_par;
      mem_dq_in <= c_dq;
   endtask

   //////////////////////////////////////////////////
   // Reference model and checks
   //////////////////////////////////////////////////

   task apply_to_model(input int cyc);
      int                 cs_low;
      int                 kind;
      logic [rank_w-1:0]  rank;
      logic [bank_w-1:0]  b;
      logic               par_ok;
      logic               is_open;
      logic               state_err;
      logic [mem_a_w-1:0] addr;
      cs_low = $countones(~c_cs_n);
      rank   = '0;
      for (int i = 0; i < n_ranks; i++) begin
         if (!c_cs_n[i]) begin
            rank = rank_w'(i);
         end
      end
      b      = {c_bg, c_ba};
      par_ok = ~^{c_par, c_act_n, c_a, c_ba, c_bg};
      if (!c_act_n) begin
         kind = op_act;
      end else begin
         case (c_a[addr_w-1 -: 3])
            3'b010:  kind = op_pre;
            3'b100:  kind = op_wr;
            3'b101:  kind = op_rd;
            default: kind = op_nop;
         endcase
      end
      is_open   = model_open[rank][b];
      state_err = (kind == op_act && is_open) ||
                  ((kind == op_wr || kind == op_rd) && !is_open);
      alert_pending = 1'b0;
      if (cs_low != 0 && (cs_low > 1 || !par_ok || state_err)) begin
         alert_pending = 1'b1;
      end else if (cs_low == 1) begin
         addr = {rank, b, model_row[rank][b], c_a[col_w-1:0]};
         case (kind)
            op_act: begin
               model_open[rank][b] = 1'b1;
               model_row[rank][b]  = c_a[row_w-1:0];
            end
            op_pre: model_open[rank][b] = 1'b0;
            op_wr: begin
               model_mem[addr]     = c_dq;
               model_written[addr] = 1'b1;
            end
            op_rd: begin
               rd_due.push_back(cyc + cas_lat);
               rd_data.push_back(model_mem[addr]);
               rd_known.push_back(model_written[addr]);
            end
            default: ;
         endcase
      end
   endtask

   task check_outputs(input int cyc);
      logic            exp_oe;
      logic [dq_w-1:0] exp_data;
      logic            known;
      int              due;
      if (mem_alert_n !== ~alert_now) begin
         $display("Mismatch in alert_pulse at cycle %0d: expected %b, actual %b",
                  cyc, ~alert_now, mem_alert_n);
         errors++;
      end
      if (alert_now) begin
         alerts_seen++;
      end
      exp_oe = (rd_due.size() > 0) && (rd_due[0] == cyc);
      if (mem_dq_oe !== exp_oe) begin
         $display("Mismatch in read_valid at cycle %0d: expected %b, actual %b",
                  cyc, exp_oe, mem_dq_oe);
         errors++;
      end
      if (exp_oe) begin
         due      = rd_due.pop_front();
         exp_data = rd_data.pop_front();
         known    = rd_known.pop_front();
         reads_seen++;
         if (known) begin
            compares++;
            if (mem_dq_out !== exp_data) begin
               $display("Mismatch in read_data at cycle %0d: expected %h, actual %h",
                        due, exp_data, mem_dq_out);
               errors++;
            end
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Run control
   //////////////////////////////////////////////////

   initial begin
      #(watchdog_ns);
      $display("Watchdog expired before the command sequence finished");
      $display("Something failed");
      $finish;
   end

   initial begin
      void'($urandom(seed));
      errors        = 0;
      reads_seen    = 0;
      compares      = 0;
      alerts_seen   = 0;
      model_open    = '0;
      model_written = '0;
      alert_pending = 1'b0;
      alert_now     = 1'b0;
      build_idle();
      drive_command();
      arst_n <= 1'b0;
      repeat (4) @(posedge mem_ck);
      @(negedge mem_ck);
      if (mem_alert_n !== 1'b1) begin
         $display("Mismatch in reset_alert: expected 1, actual %b", mem_alert_n);
         errors++;
      end
      if (mem_dq_oe !== 1'b0) begin
         $display("Mismatch in reset_oe: expected 0, actual %b", mem_dq_oe);
         errors++;
      end
      @(posedge mem_ck);
      arst_n <= 1'b1;

      // The command driven at edge i is sampled by the DUT at edge i+1
      for (int i = 0; i <= n_cmds + cas_lat; i++) begin
         @(posedge mem_ck);
         alert_now = alert_pending;
         if (i < n_cmds) begin
            build_random_command();
         end else begin
            build_idle();
         end
         drive_command();
         apply_to_model(i);
         @(negedge mem_ck);
         check_outputs(i);
      end

      $display("Summary: %0d commands, %0d reads, %0d data compares, %0d alerts, %0d errors",
               n_cmds, reads_seen, compares, alerts_seen, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
ddr_model_pkg.sv
ddr_cmd_if.sv
ddr_cmd_ctrl.sv
ddr_row_tracker.sv
ddr_storage.sv
ddr_read_pipe.sv
ddr_model_top.sv
tb_ddr_model.sv

// ==== Makefile ====
# Verilator simulation of the DDR4 memory model

VERILATOR ?= verilator
TOP       ?= tb_ddr_model
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "Everything OK" $(LOG); then \
		echo "FAIL: no result in $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
